/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// instruction field offsets
	localparam int RD_LSB     = 7;
	localparam int FUNCT3_LSB = 12;
	localparam int RS1_LSB    = 15;
	localparam int RS2_LSB    = 20;
	localparam int FUNCT7_LSB = 25;

	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011
	} opcode_e;

	// register and immediate alu ops
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// loads
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;

	// stores
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	// branches
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// sub and sra
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
endpackage

/* hdl/decode_pkg.sv */
package decode_pkg;
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_READ_8_S,
		MEM_READ_16_S,
		MEM_READ_32,
		MEM_READ_8_U,
		MEM_READ_16_U,
		MEM_WRITE_8,
		MEM_WRITE_16,
		MEM_WRITE_32
	} mem_op_e;

	typedef enum logic [1:0] {
		OP_A_RS_1,
		OP_A_PC,
		OP_A_ZERO
	} op_a_sel_e;

	typedef enum logic [1:0] {
		OP_B_RS_2,
		OP_B_IMM,
		OP_B_FOUR
	} op_b_sel_e;

	// 142 bits, valid in the msb
	typedef struct packed {
		logic                                valid;
		logic [rv_isa_pkg::XLEN-1:0]         pc;
		logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd_num;
		logic [rv_isa_pkg::XLEN-1:0]         alu_a;
		logic [rv_isa_pkg::XLEN-1:0]         alu_b;
		alu_op_e                             alu_op;
		mem_op_e                             mem_op;
		logic [rv_isa_pkg::XLEN-1:0]         store_data;
	} id_ex_t;

	typedef struct packed {
		logic                              we;
		logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_num;
		logic [rv_isa_pkg::XLEN-1:0]       value;
	} wb_t;

	typedef struct packed {
		logic                        taken;
		logic [rv_isa_pkg::XLEN-1:0] target;
	} branch_t;

	typedef struct packed {
		logic [rv_isa_pkg::XLEN-1:0] i;
		logic [rv_isa_pkg::XLEN-1:0] s;
		logic [rv_isa_pkg::XLEN-1:0] b;
		logic [rv_isa_pkg::XLEN-1:0] u;
		logic [rv_isa_pkg::XLEN-1:0] j;
	} imm_t;
endpackage

/* hdl/register_file.sv */
module register_file (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs1_num,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs2_num,
	input  decode_pkg::wb_t                   i_wb,
	output logic [rv_isa_pkg::XLEN-1:0]       o_rs_1,
	output logic [rv_isa_pkg::XLEN-1:0]       o_rs_2
);
	import rv_isa_pkg::*;

	// no storage behind x0
	logic [XLEN-1:0] regs [1:31];

	function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] num);
		logic [XLEN-1:0] value;
		if (num == '0) begin
			value = '0;
		end else if (i_wb.we && i_wb.rd_num == num) begin
			// write-first bypass
			value = i_wb.value;
		end else begin
			value = regs[num];
		end
		return value;
	endfunction

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int r = 1; r < 32; r++) begin
				regs[r] <= '0;
			end
		end else if (i_wb.we && i_wb.rd_num != '0) begin
			regs[i_wb.rd_num] <= i_wb.value;
		end
	end

	always_comb begin
		o_rs_1 = read_port(i_rs1_num);
		o_rs_2 = read_port(i_rs2_num);
	end
endmodule

/* hdl/imm_gen.sv */
module imm_gen (
	input  logic [rv_isa_pkg::XLEN-1:0] i_inst,
	output decode_pkg::imm_t            o_imm
);
	import rv_isa_pkg::*;

	logic sign;

	assign sign = i_inst[XLEN-1];

	always_comb begin
		o_imm.i = {{(XLEN-12){sign}}, i_inst[31:20]};
		o_imm.s = {{(XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};
		// b and j carry an implicit zero lsb
		o_imm.b = {
			{(XLEN-12){sign}},
			i_inst[7],
			i_inst[30:25],
			i_inst[11:8],
			1'b0
		};
		o_imm.u = {i_inst[31:12], 12'b0};
		o_imm.j = {
			{(XLEN-20){sign}},
			i_inst[19:12],
			i_inst[20],
			i_inst[30:21],
			1'b0
		};
	end
endmodule

/* hdl/branch_unit.sv */
module branch_unit (
	input  logic [rv_isa_pkg::XLEN-1:0] i_inst,
	input  logic [rv_isa_pkg::XLEN-1:0] i_pc,
	input  logic [rv_isa_pkg::XLEN-1:0] i_rs_1,
	input  logic [rv_isa_pkg::XLEN-1:0] i_rs_2,
	input  decode_pkg::imm_t            i_imm,
	input  logic                        i_stall,
	output decode_pkg::branch_t         o_branch
);
	import rv_isa_pkg::*;

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic            cmp_unsigned;
	logic            eq;
	logic            lt;
	logic            cond;
	logic [XLEN-1:0] base;
	logic [XLEN-1:0] offset;
	logic [XLEN-1:0] sum;

	assign opcode = opcode_e'(i_inst[6:0]);
	assign funct3 = i_inst[FUNCT3_LSB +: 3];

	// one comparator, extra top bit picks signed or unsigned
	assign cmp_unsigned = (funct3 == F3_BLTU) || (funct3 == F3_BGEU);
	assign eq = (i_rs_1 == i_rs_2);
	assign lt = $signed({~cmp_unsigned & i_rs_1[XLEN-1], i_rs_1})
		< $signed({~cmp_unsigned & i_rs_2[XLEN-1], i_rs_2});

	always_comb begin
		base   = (opcode == JALR) ? i_rs_1 : i_pc;
		offset = i_imm.b;
		if (opcode == JAL) begin
			offset = i_imm.j;
		end else if (opcode == JALR) begin
			offset = i_imm.i;
		end
	end

	assign sum = base + offset;

	always_comb begin
		case (funct3)
			F3_BEQ:  cond = eq;
			F3_BNE:  cond = !eq;
			F3_BLT,
			F3_BLTU: cond = lt;
			F3_BGE,
			F3_BGEU: cond = !lt;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		o_branch.target = (opcode == JALR) ? {sum[XLEN-1:1], 1'b0} : sum;
		case (opcode)
			JAL, JALR: o_branch.taken = !i_stall;
			BRANCH:    o_branch.taken = cond && !i_stall;
			default:   o_branch.taken = 1'b0;
		endcase
	end
endmodule

/* hdl/data_hazard_unit.sv */
module data_hazard_unit (
	input  logic [rv_isa_pkg::XLEN-1:0]       i_inst,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_id_ex_rd_num,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ex_mem_rd_num,
	output logic                              o_stall
);
	import rv_isa_pkg::*;

	opcode_e               opcode;
	logic [REG_ADDR_W-1:0] rs1_num;
	logic [REG_ADDR_W-1:0] rs2_num;
	logic                  rs1_used;
	logic                  rs2_used;
	logic                  rs1_hit;
	logic                  rs2_hit;

	// x0 never conflicts
	function automatic logic conflict(
		input logic [REG_ADDR_W-1:0] src,
		input logic [REG_ADDR_W-1:0] dst
	);
		return (src != '0) && (src == dst);
	endfunction

	assign opcode  = opcode_e'(i_inst[6:0]);
	assign rs1_num = i_inst[RS1_LSB +: REG_ADDR_W];
	assign rs2_num = i_inst[RS2_LSB +: REG_ADDR_W];

	assign rs1_used = !(opcode inside {LUI, AUIPC, JAL});
	assign rs2_used = opcode inside {OP, STORE, BRANCH};

	assign rs1_hit = conflict(rs1_num, i_id_ex_rd_num) || conflict(rs1_num, i_ex_mem_rd_num);
	assign rs2_hit = conflict(rs2_num, i_id_ex_rd_num) || conflict(rs2_num, i_ex_mem_rd_num);

	assign o_stall = (rs1_used && rs1_hit) || (rs2_used && rs2_hit);
endmodule

/* hdl/decode_control.sv */
module decode_control (
	input  logic [rv_isa_pkg::XLEN-1:0] i_inst,
	input  logic [rv_isa_pkg::XLEN-1:0] i_pc,
	input  logic [rv_isa_pkg::XLEN-1:0] i_rs_1,
	input  logic [rv_isa_pkg::XLEN-1:0] i_rs_2,
	input  decode_pkg::imm_t            i_imm,
	output decode_pkg::id_ex_t          o_decoded
);
	import rv_isa_pkg::*;
	import decode_pkg::*;

	opcode_e               opcode;
	logic [2:0]            funct3;
	logic                  alt;
	logic                  valid;
	logic [REG_ADDR_W-1:0] rd_num;
	logic [XLEN-1:0]       imm;
	logic [XLEN-1:0]       alu_a;
	logic [XLEN-1:0]       alu_b;
	op_a_sel_e             a_sel;
	op_b_sel_e             b_sel;
	alu_op_e               alu_op;
	mem_op_e               mem_op;

	// shared by OP and OP_IMM
	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic f7_alt);
		alu_op_e op;
		case (f3)
			F3_ADD_SUB: op = f7_alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     op = ALU_SLL;
			F3_SLT:     op = ALU_SLT;
			F3_SLTU:    op = ALU_SLTU;
			F3_XOR:     op = ALU_XOR;
			F3_SRL_SRA: op = f7_alt ? ALU_SRA : ALU_SRL;
			F3_OR:      op = ALU_OR;
			default:    op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(i_inst[6:0]);
	assign funct3 = i_inst[FUNCT3_LSB +: 3];
	assign alt    = (i_inst[FUNCT7_LSB +: 7] == FUNCT7_ALT);

	always_comb begin
		valid  = 1'b1;
		rd_num = i_inst[RD_LSB +: REG_ADDR_W];
		a_sel  = OP_A_RS_1;
		b_sel  = OP_B_IMM;
		imm    = i_imm.i;
		alu_op = ALU_ADD;
		mem_op = MEM_NONE;
		case (opcode)
			OP_IMM: begin
				// addi has no sub, funct7 only matters for shifts
				alu_op = alu_from_funct3(funct3, alt && funct3 == F3_SRL_SRA);
				if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
					imm = {{(XLEN-5){1'b0}}, i_imm.i[4:0]};
				end
			end
			OP: begin
				b_sel  = OP_B_RS_2;
				alu_op = alu_from_funct3(funct3, alt);
			end
			LUI: begin
				a_sel = OP_A_ZERO;
				imm   = i_imm.u;
			end
			AUIPC: begin
				a_sel = OP_A_PC;
				imm   = i_imm.u;
			end
			JAL, JALR: begin
				// link value
				a_sel = OP_A_PC;
				b_sel = OP_B_FOUR;
			end
			LOAD: begin
				case (funct3)
					F3_LB:   mem_op = MEM_READ_8_S;
					F3_LH:   mem_op = MEM_READ_16_S;
					F3_LW:   mem_op = MEM_READ_32;
					F3_LBU:  mem_op = MEM_READ_8_U;
					F3_LHU:  mem_op = MEM_READ_16_U;
					default: valid = 1'b0;
				endcase
			end
			STORE: begin
				rd_num = '0;
				imm    = i_imm.s;
				case (funct3)
					F3_SB:   mem_op = MEM_WRITE_8;
					F3_SH:   mem_op = MEM_WRITE_16;
					F3_SW:   mem_op = MEM_WRITE_32;
					default: valid = 1'b0;
				endcase
			end
			BRANCH: begin
				rd_num = '0;
				b_sel  = OP_B_RS_2;
				alu_op = ALU_SUB;
				if (!(funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU})) begin
					valid = 1'b0;
				end
			end
			default: valid = 1'b0;
		endcase
	end

	always_comb begin
		case (a_sel)
			OP_A_RS_1: alu_a = i_rs_1;
			OP_A_PC:   alu_a = i_pc;
			default:   alu_a = '0;
		endcase
		case (b_sel)
			OP_B_RS_2: alu_b = i_rs_2;
			OP_B_IMM:  alu_b = imm;
			default:   alu_b = XLEN'(4);
		endcase
	end

	always_comb begin
		o_decoded.valid      = valid;
		o_decoded.pc         = i_pc;
		o_decoded.rd_num     = rd_num;
		o_decoded.alu_a      = alu_a;
		o_decoded.alu_b      = alu_b;
		o_decoded.alu_op     = alu_op;
		o_decoded.mem_op     = mem_op;
		o_decoded.store_data = (opcode == STORE) ? i_rs_2 : '0;
	end
endmodule

/* hdl/stage_2.sv */
module stage_2 (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic [rv_isa_pkg::XLEN-1:0]       i_inst,
	input  logic [rv_isa_pkg::XLEN-1:0]       i_pc,
	input  decode_pkg::wb_t                   i_wb,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_id_ex_rd_num,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_ex_mem_rd_num,
	output logic                              o_stall,
	output decode_pkg::branch_t               o_branch,
	output decode_pkg::id_ex_t                o_id_ex
);
	import rv_isa_pkg::*;
	import decode_pkg::*;

	logic [XLEN-1:0] rs_1;
	logic [XLEN-1:0] rs_2;
	imm_t            imm;
	id_ex_t          decoded;

	register_file register_file_0 (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_rs1_num (i_inst[RS1_LSB +: REG_ADDR_W]),
		.i_rs2_num (i_inst[RS2_LSB +: REG_ADDR_W]),
		.i_wb      (i_wb),
		.o_rs_1    (rs_1),
		.o_rs_2    (rs_2)
	);

	imm_gen imm_gen_0 (
		.i_inst (i_inst),
		.o_imm  (imm)
	);

	data_hazard_unit data_hazard_unit_0 (
		.i_inst          (i_inst),
		.i_id_ex_rd_num  (i_id_ex_rd_num),
		.i_ex_mem_rd_num (i_ex_mem_rd_num),
		.o_stall         (o_stall)
	);

	branch_unit branch_unit_0 (
		.i_inst   (i_inst),
		.i_pc     (i_pc),
		.i_rs_1   (rs_1),
		.i_rs_2   (rs_2),
		.i_imm    (imm),
		.i_stall  (o_stall),
		.o_branch (o_branch)
	);

	decode_control decode_control_0 (
		.i_inst    (i_inst),
		.i_pc      (i_pc),
		.i_rs_1    (rs_1),
		.i_rs_2    (rs_2),
		.i_imm     (imm),
		.o_decoded (decoded)
	);

	// ID/EX register, bubble on stall or bad opcode
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_id_ex <= '0;
		end else if (o_stall || !decoded.valid) begin
			o_id_ex <= '0;
		end else begin
			o_id_ex <= decoded;
		end
	end
endmodule

/* verification/stage_2_checker.sv */
module stage_2_checker (
	input  logic                i_clk,
	input  logic                i_arst_n,
	input  logic                i_active,
	input  logic                i_exp_stall,
	input  decode_pkg::branch_t i_exp_branch,
	input  decode_pkg::id_ex_t  i_exp_id_ex,
	input  logic                i_stall,
	input  decode_pkg::branch_t i_branch,
	input  decode_pkg::id_ex_t  i_id_ex,
	output int                  o_errors
);
	timeunit 1ns;
	timeprecision 1ns;

	import decode_pkg::*;

	id_ex_t prev_exp;
	logic   have_prev;
	int     errors;

	initial begin
		prev_exp  = '0;
		have_prev = 1'b0;
		errors    = 0;
	end

	assign o_errors = errors;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge i_clk) begin
		if (i_arst_n) begin
			if (have_prev) begin
				// registered result of the previous vector
				compare("o_id_ex.valid", 32'(i_id_ex.valid), 32'(prev_exp.valid));
				compare("o_id_ex.pc", i_id_ex.pc, prev_exp.pc);
				compare("o_id_ex.rd_num", 32'(i_id_ex.rd_num), 32'(prev_exp.rd_num));
				compare("o_id_ex.alu_a", i_id_ex.alu_a, prev_exp.alu_a);
				compare("o_id_ex.alu_b", i_id_ex.alu_b, prev_exp.alu_b);
				compare("o_id_ex.alu_op", 32'(i_id_ex.alu_op), 32'(prev_exp.alu_op));
				compare("o_id_ex.mem_op", 32'(i_id_ex.mem_op), 32'(prev_exp.mem_op));
				compare("o_id_ex.store_data", i_id_ex.store_data, prev_exp.store_data);
			end else if (i_active) begin
				// still the reset value
				compare("o_id_ex.valid", 32'(i_id_ex.valid), 32'h0);
			end
			if (i_active) begin
				compare("o_stall", 32'(i_stall), 32'(i_exp_stall));
				compare("o_branch.taken", 32'(i_branch.taken), 32'(i_exp_branch.taken));
				if (i_exp_branch.taken) begin
					compare("o_branch.target", i_branch.target, i_exp_branch.target);
				end
			end
			prev_exp  = i_exp_id_ex;
			have_prev = i_active;
		end
	end
endmodule

/* verification/stage_2_asserts.sv */
module stage_2_asserts (
	input logic                i_clk,
	input logic                i_arst_n,
	input logic                i_stall,
	input decode_pkg::branch_t i_branch,
	input decode_pkg::id_ex_t  i_id_ex
);
	timeunit 1ns;
	timeprecision 1ns;

	int fails = 0;

	no_taken_while_stalled: assert property (
		@(posedge i_clk) disable iff (!i_arst_n) !(i_branch.taken && i_stall)
	) else begin
		fails++;
		$error("branch taken while stalled");
	end

	// stall forces a bubble into ID/EX
	bubble_after_stall: assert property (
		@(posedge i_clk) disable iff (!i_arst_n) i_stall |=> !i_id_ex.valid
	) else begin
		fails++;
		$error("ID/EX valid after a stall cycle");
	end

	invalid_after_reset: assert property (
		@(posedge i_clk) !i_arst_n |=> !i_id_ex.valid
	) else begin
		fails++;
		$error("ID/EX valid after reset");
	end
endmodule

bind stage_2 stage_2_asserts stage_2_asserts_0 (
	.i_clk    (i_clk),
	.i_arst_n (i_arst_n),
	.i_stall  (o_stall),
	.i_branch (o_branch),
	.i_id_ex  (o_id_ex)
);

/* verification/tb_stage_2.sv */
module tb_stage_2;
	timeunit 1ns;
	timeprecision 1ns;

	import decode_pkg::*;

	localparam int NUM_VEC   = 47;
	localparam int VEC_WORDS = 18;
	localparam int RESET_CYCLES = 16;

	logic        clk = 1'b0;
	logic        arst_n;
	logic [31:0] inst;
	logic [31:0] pc;
	wb_t         wb;
	logic [4:0]  id_ex_rd_num;
	logic [4:0]  ex_mem_rd_num;
	logic        stall;
	branch_t     branch;
	id_ex_t      id_ex;

	logic        active;
	logic        exp_stall;
	branch_t     exp_branch;
	id_ex_t      exp_id_ex;
	int          errors;

	logic [31:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];

	always #50 clk = ~clk;

	stage_2 i_stage_2 (
		.i_clk           (clk),
		.i_arst_n        (arst_n),
		.i_inst          (inst),
		.i_pc            (pc),
		.i_wb            (wb),
		.i_id_ex_rd_num  (id_ex_rd_num),
		.i_ex_mem_rd_num (ex_mem_rd_num),
		.o_stall         (stall),
		.o_branch        (branch),
		.o_id_ex         (id_ex)
	);

	stage_2_checker checker_0 (
		.i_clk        (clk),
		.i_arst_n     (arst_n),
		.i_active     (active),
		.i_exp_stall  (exp_stall),
		.i_exp_branch (exp_branch),
		.i_exp_id_ex  (exp_id_ex),
		.i_stall      (stall),
		.i_branch     (branch),
		.i_id_ex      (id_ex),
		.o_errors     (errors)
	);

	// expected values travel with their vector
	task automatic apply_vector(input int k);
		int b;
		b = k * VEC_WORDS;
		inst          <= vec_mem[b];
		pc            <= vec_mem[b+1];
		id_ex_rd_num  <= vec_mem[b+2][4:0];
		ex_mem_rd_num <= vec_mem[b+3][4:0];
		wb            <= '{
			we: vec_mem[b+4][0],
			rd_num: vec_mem[b+5][4:0],
			value: vec_mem[b+6]
		};
		exp_stall     <= vec_mem[b+7][0];
		exp_branch    <= '{taken: vec_mem[b+8][0], target: vec_mem[b+9]};
		exp_id_ex     <= '{
			valid: vec_mem[b+10][0],
			pc: vec_mem[b+11],
			rd_num: vec_mem[b+12][4:0],
			alu_a: vec_mem[b+13],
			alu_b: vec_mem[b+14],
			alu_op: alu_op_e'(vec_mem[b+15][3:0]),
			mem_op: mem_op_e'(vec_mem[b+16][3:0]),
			store_data: vec_mem[b+17]
		};
		active        <= 1'b1;
	endtask

	initial begin
		arst_n        = 1'b0;
		inst          = '0;
		pc            = '0;
		wb            = '0;
		id_ex_rd_num  = '0;
		ex_mem_rd_num = '0;
		active        = 1'b0;
		exp_stall     = 1'b0;
		exp_branch    = '0;
		exp_id_ex     = '0;
		$readmemh("verification/stage_2_testdata.hex", vec_mem);
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int k = 0; k < NUM_VEC; k++) begin
			@(posedge clk);
			apply_vector(k);
		end
		@(posedge clk);
		active <= 1'b0;
		inst   <= '0;
		wb     <= '0;
		repeat (2) @(posedge clk);
		$display("closing report: %0d mismatch(es), %0d assertion failure(s)",
			errors, i_stage_2.stage_2_asserts_0.fails);
		if (errors == 0 && i_stage_2.stage_2_asserts_0.fails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog sized from the vector count
	initial begin
		#((NUM_VEC + RESET_CYCLES + 20) * 100);
		$display("timeout: the test did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end
endmodule

/* verification/stage_2_testdata.hex */
// inst pc id_ex_rd ex_mem_rd wb_we wb_rd wb_val | stall taken target
// | exp: valid pc rd alu_a alu_b alu_op mem_op store_data
00500093 100 0 0 1 1 10 0 0 0 1 100 1 0 5 0 0 0
002082B3 104 0 0 1 2 FFFFFFF0 0 0 0 1 104 5 10 FFFFFFF0 0 0 0
40208333 108 0 0 1 3 10 0 0 0 1 108 6 10 FFFFFFF0 1 0 0
0020A3B3 10C 0 0 1 4 5 0 0 0 1 10C 7 10 FFFFFFF0 2 0 0
0000B433 110 0 0 1 0 DEADBEEF 0 0 0 1 110 8 10 0 3 0 0
003144B3 114 0 0 0 0 0 0 0 0 1 114 9 FFFFFFF0 10 6 0 0
0040E533 118 0 0 0 0 0 0 0 0 1 118 A 10 5 5 0 0
0041F5B3 11C 0 0 0 0 0 0 0 0 1 11C B 10 5 4 0 0
00409633 120 0 0 0 0 0 0 0 0 1 120 C 10 5 7 0 0
004156B3 124 0 0 0 0 0 0 0 0 1 124 D FFFFFFF0 5 8 0 0
40415733 128 0 0 0 0 0 0 0 0 1 128 E FFFFFFF0 5 9 0 0
FFF12793 12C 0 0 0 0 0 0 0 0 1 12C F FFFFFFF0 FFFFFFFF 2 0 0
7FF0B813 130 0 0 0 0 0 0 0 0 1 130 10 10 7FF 3 0 0
0F00C893 134 0 0 0 0 0 0 0 0 1 134 11 10 F0 6 0 0
10026913 138 0 0 0 0 0 0 0 0 1 138 12 5 100 5 0 0
0FF17993 13C 0 0 0 0 0 0 0 0 1 13C 13 FFFFFFF0 FF 4 0 0
00309A13 140 0 0 0 0 0 0 0 0 1 140 14 10 3 7 0 0
00415A93 144 0 0 0 0 0 0 0 0 1 144 15 FFFFFFF0 4 8 0 0
40415B13 148 0 0 0 0 0 0 0 0 1 148 16 FFFFFFF0 4 9 0 0
0080AB83 14C 0 0 0 0 0 0 0 0 1 14C 17 10 8 0 3 0
FFC14C03 150 0 0 0 0 0 0 0 0 1 150 18 FFFFFFF0 FFFFFFFC 0 4 0
00221C83 154 0 0 0 0 0 0 0 0 1 154 19 5 2 0 2 0
0040A623 158 0 0 0 0 0 0 0 0 1 158 0 10 C 0 8 5
FE218FA3 15C 0 0 0 0 0 0 0 0 1 15C 0 10 FFFFFFFF 0 6 FFFFFFF0
12345D37 160 0 0 0 0 0 0 0 0 1 160 1A 0 12345000 0 0 0
80000D97 164 0 0 0 0 0 0 0 0 1 164 1B 164 80000000 0 0 0
00308463 168 0 0 0 0 0 0 1 170 1 168 0 10 10 1 0 0
00208463 16C 0 0 0 0 0 0 0 0 1 16C 0 10 FFFFFFF0 1 0 0
FE209CE3 170 0 0 0 0 0 0 1 168 1 170 0 10 FFFFFFF0 1 0 0
00309463 174 0 0 0 0 0 0 0 0 1 174 0 10 10 1 0 0
00114463 178 0 0 0 0 0 0 1 180 1 178 0 FFFFFFF0 10 1 0 0
0020C463 17C 0 0 0 0 0 0 0 0 1 17C 0 10 FFFFFFF0 1 0 0
0020D463 180 0 0 0 0 0 0 1 188 1 180 0 10 FFFFFFF0 1 0 0
00125463 184 0 0 0 0 0 0 0 0 1 184 0 5 10 1 0 0
0020E463 188 0 0 0 0 0 0 1 190 1 188 0 10 FFFFFFF0 1 0 0
00116463 18C 0 0 0 0 0 0 0 0 1 18C 0 FFFFFFF0 10 1 0 0
00117463 190 0 0 0 0 0 0 1 198 1 190 0 FFFFFFF0 10 1 0 0
00127463 194 0 0 0 0 0 0 0 0 1 194 0 5 10 1 0 0
100000EF 198 0 0 0 0 0 0 1 298 1 198 1 198 4 0 0 0
003082E7 19C 0 0 0 0 0 0 1 12 1 19C 5 19C 4 0 0 0
002082B3 1A0 1 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0
00308463 1A4 0 3 0 0 0 1 0 0 0 0 0 0 0 0 0 0
12345D37 1A8 8 0 0 0 0 0 0 0 1 1A8 1A 0 12345000 0 0 0
00500093 1AC 0 5 0 0 0 0 0 0 1 1AC 1 0 5 0 0 0
0040A623 1B0 0 4 0 0 0 1 0 0 0 0 0 0 0 0 0 0
00000000 1B4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
00500093 1B8 0 0 0 0 0 0 0 0 1 1B8 1 0 5 0 0 0

/* build.f */
hdl/rv_isa_pkg.sv
hdl/decode_pkg.sv
hdl/register_file.sv
hdl/imm_gen.sv
hdl/branch_unit.sv
hdl/data_hazard_unit.sv
hdl/decode_control.sv
hdl/stage_2.sv
verification/stage_2_checker.sv
verification/stage_2_asserts.sv
verification/tb_stage_2.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_stage_2 -f build.f \
	&& ./obj_dir/Vtb_stage_2 > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
